//--- fetch_pkg.sv
// fetch front end shared widths, reset vector and opcode constants
package fetch_pkg;

  // datapath widths
  localparam int PC_WD        = 32;  // program counter
  localparam int INST_WD      = 32;  // one RV32 instruction

  // instruction SRAM port
  // byte address, the SRAM itself ignores bits [2:0]
  localparam int SRAM_ADDR_WD = 32;
  localparam int SRAM_DATA_WD = 64;  // two instructions per word

  // first fetch address after reset
  localparam logic [PC_WD-1:0] PC_RESETVAL = 32'h8000_0000;

  // sequential fetch step
  localparam logic [PC_WD-1:0] INST_BYTES = 32'd4;

  // major opcode of JAL, inst[6:0]
  localparam logic [6:0] OPC_JAL = 7'b1101111;

  // J-type immediate layout in the instruction word
  //   imm[20]    = inst[31]
  //   imm[10:1]  = inst[30:21]
  //   imm[11]    = inst[20]
  //   imm[19:12] = inst[19:12]
  //   imm[0]     = 0
  // the result is sign extended from imm[20] up to PC_WD bits

  // all stage-to-stage traffic uses valid/allowin levels
  // an item moves on a rising clock edge when both are high
  // no stage adds wait states, so each ready_go is always high
  // and is not carried as a signal
  // a taken JAL costs one bubble behind it

endpackage

//--- pc_gen.sv
// pre-IF PC generator, holds the fetch PC and picks the next fetch address
`timescale 1ns/100ps

module pc_gen import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_load,          // IF can take a new item
  input  logic                    i_br_sel,        // JAL redirect from ID
  input  logic [PC_WD-1:0]        i_br_target,
  output logic [PC_WD-1:0]        o_pc,            // PC of the word now in IF
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic [PC_WD-1:0] pc;       // fetch PC, lines up with SRAM read data
  logic [PC_WD-1:0] seq_pc;   // straight-line successor
  logic [PC_WD-1:0] next_pc;  // address issued this cycle

  assign seq_pc  = pc + INST_BYTES;

  // redirect has priority over the sequential step
  // the target stays put while ID holds the JAL, so a stalled
  // load simply retries with the same address next cycle
  assign next_pc = i_br_sel ? i_br_target : seq_pc;

  // reset value sits one step below the vector
  // so the first issued address is PC_RESETVAL itself
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc <= PC_RESETVAL - INST_BYTES;
    end else if (i_load) begin
      pc <= next_pc;  // same cycle as the SRAM read below
    end
  end

  assign o_pc = pc;

  // SRAM sees the address the PC register is about to take,
  // so read data and pc line up one cycle later
  assign o_inst_sram_ren  = i_load;
  assign o_inst_sram_addr = SRAM_ADDR_WD'(next_pc);

  // a misaligned target from ID would split an instruction
  // across the two halves of the SRAM word
  a_next_pc_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_load |-> (next_pc[1:0] == 2'b00)
  ) else $error("pc_gen: misaligned fetch address %h", next_pc);

endmodule

//--- if_stage.sv
// IF stage, fetch valid and allowin control plus 64-to-32 instruction select
`timescale 1ns/100ps

module if_stage import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  // allowin from ID
  input  logic                    i_ds_allowin,
  // branch bus from ID
  input  logic                    i_br_sel,
  input  logic [PC_WD-1:0]        i_br_target,
  // read data from inst sram
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  // to ID
  output logic                    o_fs_to_ds_valid,
  output logic [INST_WD-1:0]      o_fs_inst,
  output logic [PC_WD-1:0]        o_fs_pc,
  // inst sram request
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic             to_fs_valid;  // pre-IF has a request pending
  logic             fs_valid;
  logic             fs_allowin;
  logic             fs_load;      // pre-IF item enters IF at next edge
  logic [PC_WD-1:0] fs_pc;

  // pre-IF starts asking one cycle after reset release
  // which keeps the SRAM read strobe quiet through that first cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      to_fs_valid <= 1'b0;
    end else begin
      to_fs_valid <= 1'b1;
    end
  end

  // empty IF always takes a new item, a full one only when ID takes its current one
  assign fs_allowin = !fs_valid || i_ds_allowin;
  assign fs_load    = to_fs_valid && fs_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= to_fs_valid;
    end
  end

  pc_gen u_pc (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_load           (fs_load),
    .i_br_sel         (i_br_sel),     // JAL resolved in ID
    .i_br_target      (i_br_target),
    .o_pc             (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  assign o_fs_to_ds_valid = fs_valid;
  assign o_fs_pc          = fs_pc;

  // SRAM word is 8-byte aligned
  // pc[2] picks the upper or lower instruction
  assign o_fs_inst = fs_pc[2] ? i_inst_sram_rdata[SRAM_DATA_WD-1:INST_WD]
                              : i_inst_sram_rdata[INST_WD-1:0];

  // a stalled IF keeps its item until ID opens again
  a_fs_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_fs_to_ds_valid && !i_ds_allowin) |=>
      (o_fs_to_ds_valid && $stable(o_fs_pc))
  ) else $error("if_stage: item lost or changed under back-pressure, pc %h", o_fs_pc);

endmodule

//--- id_stage.sv
// ID stage, holds the fetched item, resolves JAL and cancels the wrong-path fetch
`timescale 1ns/100ps

module id_stage import fetch_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst_n,
  // from IF
  input  logic               i_fs_to_ds_valid,
  input  logic [INST_WD-1:0] i_fs_inst,
  input  logic [PC_WD-1:0]   i_fs_pc,
  // allowin from downstream
  input  logic               i_es_allowin,
  // allowin to IF
  output logic               o_ds_allowin,
  // branch bus to IF
  output logic               o_br_sel,
  output logic [PC_WD-1:0]   o_br_target,
  // to downstream
  output logic               o_ds_valid,
  output logic [INST_WD-1:0] o_ds_inst,
  output logic [PC_WD-1:0]   o_ds_pc
);

  logic               ds_valid;
  logic               ds_allowin;
  logic [INST_WD-1:0] ds_inst;
  logic [PC_WD-1:0]   ds_pc;
  logic               is_jal;
  logic               br_taken;   // valid JAL held in ID
  logic [PC_WD-1:0]   j_imm;

  // ID never needs more than one cycle
  assign ds_allowin = !ds_valid || i_es_allowin;

  // while a JAL leaves, the item coming in behind it is PC+4
  // and must not reach the output
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !br_taken;
    end
  end

  // payload only moves with a real item so a stalled output stays put
  always_ff @(posedge i_clk) begin
    if (ds_allowin && i_fs_to_ds_valid) begin
      ds_inst <= i_fs_inst;
      ds_pc   <= i_fs_pc;
    end
  end

  // decode, only JAL matters to the front end
  assign is_jal   = (ds_inst[6:0] == OPC_JAL);
  assign br_taken = ds_valid && is_jal;

  // J-type immediate, sign bit is inst[31]
  assign j_imm = {{(PC_WD-21){ds_inst[31]}},
                  ds_inst[31],
                  ds_inst[19:12],
                  ds_inst[20],
                  ds_inst[30:21],
                  1'b0};

  // held steady for as long as the JAL sits in ID
  assign o_br_sel    = br_taken;
  assign o_br_target = ds_pc + j_imm;

  assign o_ds_allowin = ds_allowin;
  assign o_ds_valid   = ds_valid;
  assign o_ds_inst    = ds_inst;
  assign o_ds_pc      = ds_pc;

  // item entering behind a leaving JAL is the wrong-path PC+4
  // and has to come out invalid
  a_wrong_path_dropped: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_br_sel && o_ds_allowin) |=> !o_ds_valid
  ) else $error("id_stage: wrong-path fetch kept behind a JAL");

endmodule

//--- fetch_top.sv
// fetch front end top, IF and ID stages between the inst SRAM and the downstream port
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_es_allowin,      // downstream back-pressure
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  output logic                    o_ds_valid,
  output logic [INST_WD-1:0]      o_ds_inst,
  output logic [PC_WD-1:0]        o_ds_pc
);

  logic               fs_to_ds_valid;
  logic [INST_WD-1:0] fs_inst;
  logic [PC_WD-1:0]   fs_pc;
  logic               ds_allowin;
  logic               br_sel;       // branch bus back to IF
  logic [PC_WD-1:0]   br_target;

  if_stage u_if (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_ds_allowin      (ds_allowin),
    .i_br_sel          (br_sel),
    .i_br_target       (br_target),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_inst         (fs_inst),
    .o_fs_pc           (fs_pc),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr)
  );

  id_stage u_id (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_inst        (fs_inst),
    .i_fs_pc          (fs_pc),
    .i_es_allowin     (i_es_allowin),
    .o_ds_allowin     (ds_allowin),
    .o_br_sel         (br_sel),
    .o_br_target      (br_target),
    .o_ds_valid       (o_ds_valid),
    .o_ds_inst        (o_ds_inst),
    .o_ds_pc          (o_ds_pc)
  );

endmodule

//--- tb_inst_sram.sv
// instruction SRAM model for the testbench, 64-bit words read back one clock later
`timescale 1ns/100ps

module tb_inst_sram import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_ren,
  input  logic [SRAM_ADDR_WD-1:0] i_addr,
  output logic [SRAM_DATA_WD-1:0] o_rdata
);

  logic [SRAM_DATA_WD-1:0] mem [0:1023];  // 8 KB, wraps on addr[12:3]

  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      o_rdata <= mem[i_addr[12:3]];
    end
  end

  // non-JAL OP-IMM word, upper bits are a tag built from the whole address
  function automatic logic [INST_WD-1:0] plain_inst(input logic [PC_WD-1:0] addr);
    return {addr[26:2] ^ {20'h0, addr[31:27]}, 7'b0010011};
  endfunction

  task automatic fill_plain();
    logic [PC_WD-1:0] addr;
    for (int i = 0; i < 1024; i++) begin
      addr = PC_RESETVAL + 32'(i * 8);
      mem[i[9:0]] = {plain_inst(addr + INST_BYTES), plain_inst(addr)};
    end
  endtask

  // pc[2] picks the half, rest of the word untouched
  task automatic write_inst(input logic [PC_WD-1:0] pc, input logic [INST_WD-1:0] inst);
    if (pc[2]) begin
      mem[pc[12:3]][SRAM_DATA_WD-1:INST_WD] = inst;
    end else begin
      mem[pc[12:3]][INST_WD-1:0] = inst;
    end
  endtask

  // JAL with rd = x1, offset in bytes relative to pc
  task automatic put_jal(input logic [PC_WD-1:0] pc, input int offset);
    logic [20:0] imm;
    imm = offset[20:0];
    write_inst(pc, {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL});
  endtask

  function automatic logic [INST_WD-1:0] peek_inst(input logic [PC_WD-1:0] pc);
    logic [SRAM_DATA_WD-1:0] word;
    word = mem[pc[12:3]];
    return pc[2] ? word[SRAM_DATA_WD-1:INST_WD] : word[INST_WD-1:0];
  endfunction

endmodule

//--- tb_fetch.sv
// testbench for the fetch front end, directed tests against a reference PC stream
`timescale 1ns/100ps

module tb_fetch import fetch_pkg::*; ();

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    es_allowin;
  logic [SRAM_DATA_WD-1:0] sram_rdata;
  logic                    sram_ren;
  logic [SRAM_ADDR_WD-1:0] sram_addr;
  logic                    ds_valid;
  logic [INST_WD-1:0]      ds_inst;
  logic [PC_WD-1:0]        ds_pc;

  logic [PC_WD-1:0]        exp_pc;    // next PC the reference stream expects

  always #20 clk = ~clk;  // 40 ns period

  fetch_top uut (
    .i_clk             (clk),
    .i_rst_n           (rst_n),
    .i_es_allowin      (es_allowin),
    .i_inst_sram_rdata (sram_rdata),
    .o_inst_sram_ren   (sram_ren),
    .o_inst_sram_addr  (sram_addr),
    .o_ds_valid        (ds_valid),
    .o_ds_inst         (ds_inst),
    .o_ds_pc           (ds_pc)
  );

  tb_inst_sram u_sram (
    .i_clk   (clk),
    .i_ren   (sram_ren),
    .i_addr  (sram_addr),
    .o_rdata (sram_rdata)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input string what,
                           input logic [31:0] exp_val, input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      fail_run($sformatf("ERROR %s: %s expected %h actual %h", name, what, exp_val, act_val));
    end
  endtask

  // RISC-V J-type immediate, sign bit is inst[31]
  function automatic logic [PC_WD-1:0] jal_target(input logic [PC_WD-1:0] pc,
                                                  input logic [INST_WD-1:0] inst);
    logic [20:0] imm;
    imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    return pc + {{11{imm[20]}}, imm};
  endfunction

  // program order, a JAL jumps, anything else falls through
  function automatic logic [PC_WD-1:0] ref_next(input logic [PC_WD-1:0] pc);
    logic [INST_WD-1:0] inst;
    inst = u_sram.peek_inst(pc);
    if (inst[6:0] == OPC_JAL) begin
      return jal_target(pc, inst);
    end
    return pc + INST_BYTES;
  endfunction

  task automatic enter_reset();
    @(negedge clk);
    rst_n      = 1'b0;
    es_allowin = 1'b0;
  endtask

  // 4 cycles in reset, then release with the reference stream at the vector
  task automatic leave_reset(input string name);
    repeat (4) begin
      @(negedge clk);
      check_val(name, "o_ds_valid in reset", 32'd0, 32'(ds_valid));
      check_val(name, "o_inst_sram_ren in reset", 32'd0, 32'(sram_ren));
    end
    rst_n  = 1'b1;
    exp_pc = PC_RESETVAL;
    #1;  // sample once the release has settled
    check_val(name, "o_ds_valid after reset", 32'd0, 32'(ds_valid));
    check_val(name, "o_inst_sram_ren after reset", 32'd0, 32'(sram_ren));
    check_val(name, "o_inst_sram_addr after reset", PC_RESETVAL, sram_addr);
    @(negedge clk);
  endtask

  // runs at falling edges, an item counts when valid and allowin meet at the next rise
  task automatic collect_items(input string name, input int count, input bit random_bp);
    int                      got;
    int                      idle;
    bit                      held;
    logic [PC_WD-1:0]        held_pc;
    logic [INST_WD-1:0]      held_inst;
    logic [SRAM_ADDR_WD-1:0] held_addr;
    logic [INST_WD-1:0]      exp_inst;
    got       = 0;
    idle      = 0;
    held      = 1'b0;
    held_pc   = '0;
    held_inst = '0;
    held_addr = '0;
    while (got < count) begin
      es_allowin = random_bp ? (($urandom % 4) != 0) : 1'b1;
      if (held) begin  // stalled item must not move
        check_val(name, "held o_ds_valid", 32'd1, 32'(ds_valid));
        check_val(name, "held o_ds_pc", held_pc, ds_pc);
        check_val(name, "held o_ds_inst", held_inst, ds_inst);
        check_val(name, "held o_inst_sram_addr", held_addr, sram_addr);
      end
      held      = ds_valid && !es_allowin;
      held_pc   = ds_pc;
      held_inst = ds_inst;
      held_addr = sram_addr;
      if (ds_valid && es_allowin) begin
        exp_inst = u_sram.peek_inst(exp_pc);
        check_val(name, "o_ds_pc", exp_pc, ds_pc);
        check_val(name, "o_ds_inst", exp_inst, ds_inst);
        exp_pc   = ref_next(exp_pc);
        got++;
        idle = 0;
      end else begin
        idle++;
        assert (idle < 64) else begin  // far above any legal gap
          fail_run($sformatf("timeout in %s, no item accepted for %0d cycles", name, idle));
        end
      end
      @(negedge clk);
    end
  endtask

  task automatic test_reset();
    enter_reset();
    u_sram.fill_plain();
    leave_reset("reset");
    collect_items("reset", 1, 1'b0);
  endtask

  task automatic test_sequential();
    enter_reset();
    u_sram.fill_plain();
    leave_reset("sequential");
    collect_items("sequential", 40, 1'b0);
  endtask

  task automatic test_backpressure();
    enter_reset();
    u_sram.fill_plain();
    leave_reset("backpressure");
    collect_items("backpressure", 60, 1'b1);
  endtask

  task automatic test_redirect();
    enter_reset();
    u_sram.fill_plain();
    u_sram.put_jal(PC_RESETVAL + 32'h10, 68);   // forward to 0x54, high half
    u_sram.put_jal(PC_RESETVAL + 32'h64, -44);  // back to 0x38
    leave_reset("redirect");
    collect_items("redirect", 40, 1'b0);
  endtask

  task automatic test_stress();
    enter_reset();
    u_sram.fill_plain();
    u_sram.put_jal(PC_RESETVAL + 32'h08, 32);    // lands on another JAL
    u_sram.put_jal(PC_RESETVAL + 32'h0c, 100);   // wrong path only
    u_sram.put_jal(PC_RESETVAL + 32'h28, 64);
    u_sram.put_jal(PC_RESETVAL + 32'h6c, 20);
    u_sram.put_jal(PC_RESETVAL + 32'h70, -112);  // wrong path only
    u_sram.put_jal(PC_RESETVAL + 32'h80, 8);     // three JALs in a row from 0x6c
    u_sram.put_jal(PC_RESETVAL + 32'h88, -136);  // back to the vector
    leave_reset("stress");
    collect_items("stress", 100, 1'b1);
  endtask

  initial begin
    rst_n      = 1'b0;
    es_allowin = 1'b0;
    void'($urandom(32'h71b0_dd70));
    test_reset();
    test_sequential();
    test_backpressure();
    test_redirect();
    test_stress();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- sim.f
fetch_pkg.sv
pc_gen.sv
if_stage.sv
id_stage.sv
fetch_top.sv
tb_inst_sram.sv
tb_fetch.sv

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert -f sim.f --top-module tb_fetch -Mdir "$OBJ" -o Vtb_fetch
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/Vtb_fetch" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi

exit 0
